// ==== verif/conv_unit_testdata.txt ====
# B start last pixel w0 w1 w2   one beat, start opens a frame before this beat
# E value                        expected m_data, in output order
B 1 1 2 1 -1 3
B 0 0 1 2 0 -1
B 0 0 -3 1 4 2
B 0 1 5 -2 1 1
B 0 0 4 1 1 1
B 0 0 -2 3 -1 2
B 0 0 7 0 2 -3
B 0 0 1 -5 6 10
B 0 1 -1 2 2 2
E -18
B 0 1 -6 1 2 -1
E 19
B 0 0 3 2 -2 1
B 0 0 -1 4 1 0
B 0 1 2 -3 5 7
E -4
B 0 0 1 1 2 3
B 0 0 -2 1 2 3
B 0 0 3 1 2 3
B 0 0 -4 1 2 3
B 0 1 10 -1 0 1
E 1
B 1 0 -32768 32767 -32768 1
B 0 0 100 10 20 30
B 0 0 -50 2 -2 4
B 0 0 0 9 9 9
B 0 1 1 1 1 1
B 0 1 7 3 -4 5
B 0 0 2 6 1 -1
B 0 0 -5 2 3 4
B 0 1 3 -1 8 2
E -1073708199
B 0 0 -1 5 5 5
B 0 0 4 -2 3 -6
B 0 1 6 1 0 2
E 15
B 0 1 -9 2 -3 4
E -30
B 0 0 1 4 -1 2
B 0 0 2 -3 2 1
B 0 0 -3 1 1 -2
B 0 0 5 2 0 -1
B 0 1 -1 0 3 3
E 22
B 1 0 3 1 2 3
B 0 0 3 1 2 3
B 0 1 -2 4 -4 1
B 0 0 1 1 0 0
B 0 0 2 0 1 0
B 0 0 3 0 0 1
B 0 0 -4 1 1 1
B 0 1 5 -1 -1 -1
B 0 1 8 -2 3 -5
E -49
B 0 1 -7 3 3 -3
E 37
B 0 0 2 1 1 1
B 0 0 2 2 2 2
B 0 0 -3 1 -1 2
B 0 0 1 6 5 4
B 0 1 -2 3 0 -3
E -27
B 0 0 4 -1 2 0
B 0 0 -6 1 1 1
B 0 1 2 5 -3 9
E 5

// ==== verilog.f ====
hw/conv_format_pkg.sv
hw/conv_timing_pkg.sv
hw/mac_lanes.sv
hw/column_tracker.sv
hw/snake_chain.sv
hw/conv_unit.sv
verif/conv_unit_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module conv_unit_tb -Mdir obj_dir
	./obj_dir/Vconv_unit_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/conv_unit_tb.sv ====
// reads verif/conv_unit_testdata.txt relative to the run directory; expects three weights per beat
`default_nettype none

module conv_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // bench constants
    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_MARGIN = 200;
    localparam int IDLE_GAP       = conv_timing_pkg::OUT_LATENCY + 1;

    localparam int DW = conv_format_pkg::DATA_WIDTH;
    localparam int KW = conv_format_pkg::KERNEL_W;
    localparam int AW = conv_format_pkg::ACC_WIDTH;

    // dut ports
    logic                 aclk;
    logic                 rst_n;
    logic                 aclken;
    logic                 start;
    logic                 s_valid;
    logic signed [DW-1:0] s_pixel;
    logic [KW*DW-1:0]     s_weights;
    logic                 s_last;
    logic                 s_ready;
    logic                 m_valid;
    logic signed [AW-1:0] m_data;

    // beats and expected results from the data file
    bit                   start_q   [$];
    bit                   last_q    [$];
    logic signed [DW-1:0] pixel_q   [$];
    logic [KW*DW-1:0]     weights_q [$];
    longint               expect_q  [$];
    int                   expect_idx;

    // back-pressure source
    integer seed;
    bit     bp_enable;

    // run limit
    int cycle_count;
    int cycle_limit;

    conv_unit conv_unit_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .aclken    (aclken),
        .start     (start),
        .s_valid   (s_valid),
        .s_pixel   (s_pixel),
        .s_weights (s_weights),
        .s_last    (s_last),
        .s_ready   (s_ready),
        .m_valid   (m_valid),
        .m_data    (m_data)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // print the reason, then the fail message, then stop
    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    // one line per beat or per expected result
    task automatic load_testdata();
        int          fd;
        int          n;
        int          st;
        int          la;
        int          px;
        int          w [KW];
        longint      ev;
        string       line;
        byte         c;
        logic [KW*DW-1:0] wbus;
        fd = $fopen("verif/conv_unit_testdata.txt", "r");
        if (fd == 0) begin
            stop_on_failure("could not open the test data file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0) begin
                continue;
            end
            c = line.getc(0);
            if (c == "B") begin
                n = $sscanf(line, "B %d %d %d %d %d %d", st, la, px, w[0], w[1], w[2]);
                if (n != 6) begin
                    stop_on_failure({"malformed beat line in test data: ", line});
                end
                // lane 0 weight in the low bits
                wbus = '0;
                for (int k = 0; k < KW; k++) begin
                    wbus[k*DW +: DW] = w[k][DW-1:0];
                end
                start_q.push_back(st != 0);
                last_q.push_back(la != 0);
                pixel_q.push_back(px[DW-1:0]);
                weights_q.push_back(wbus);
            end else if (c == "E") begin
                n = $sscanf(line, "E %d", ev);
                if (n != 1) begin
                    stop_on_failure({"malformed expected line in test data: ", line});
                end
                expect_q.push_back(ev);
            end else if (c != "#" && c != "\n" && c != " " && c != "\r") begin
                stop_on_failure({"unknown line kind in test data: ", line});
            end
        end
        $fclose(fd);
    endtask

    // hold s_valid low for n enabled cycles
    task automatic wait_idle(input int n);
        int seen;
        seen = 0;
        s_valid <= 1'b0;
        s_last  <= 1'b0;
        while (seen < n) begin
            @(posedge aclk);
            if (aclken) begin
                seen++;
            end
        end
    endtask

    // start pulse kept until an enabled edge has seen it
    task automatic pulse_start();
        start <= 1'b1;
        @(posedge aclk);
        while (!aclken) begin
            @(posedge aclk);
        end
        start <= 1'b0;
    endtask

    // present one beat until it is taken
    task automatic drive_beat(input int i);
        s_valid   <= 1'b1;
        s_pixel   <= pixel_q[i];
        s_weights <= weights_q[i];
        s_last    <= last_q[i];
        @(posedge aclk);
        while (!aclken) begin
            @(posedge aclk);
        end
    endtask

    // roughly one frozen cycle in four
    always @(posedge aclk) begin
        if (bp_enable) begin
            aclken <= (($random(seed) & 3) != 0);
        end
    end

    // outputs are stable at the falling edge
    always @(negedge aclk) begin
        longint want;
        // input side accepts exactly when the unit advances
        assert (s_ready === aclken) else begin
            $display("ERR %0d ns: s_ready %b while aclken %b", $time, s_ready, aclken);
            stop_on_failure("s_ready does not follow aclken");
        end
        if (rst_n && aclken && m_valid) begin
            if (expect_idx >= expect_q.size()) begin
                stop_on_failure($sformatf("unexpected extra result %0d at %0d ns",
                                          m_data, $time));
            end else begin
                want = expect_q[expect_idx];
                expect_idx++;
                assert (longint'(m_data) == want) else begin
                    $display("ERR %0d ns: result %0d expected %0d got %0d",
                             $time, expect_idx - 1, want, m_data);
                    stop_on_failure("wrong result value");
                end
            end
        end
    end

    // limit from the beat count
    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            stop_on_failure($sformatf("run timed out after %0d cycles", cycle_count));
        end
    end

    initial begin
        seed        = 3987;
        bp_enable   = 1'b0;
        cycle_count <= 0;
        cycle_limit = 0;
        expect_idx  = 0;
        rst_n       <= 1'b0;
        aclken      <= 1'b1;
        start       <= 1'b0;
        s_valid     <= 1'b0;
        s_pixel     <= '0;
        s_weights   <= '0;
        s_last      <= 1'b0;

        load_testdata();
        cycle_limit = 2 * pixel_q.size() + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;

        // quiet output before any input
        repeat (4) begin
            @(negedge aclk);
            assert (!m_valid) else begin
                stop_on_failure("m_valid high after reset with no input");
            end
        end

        @(posedge aclk);
        bp_enable = 1'b1;

        for (int i = 0; i < pixel_q.size(); i++) begin
            // new frame only once the pipe is empty
            if (start_q[i]) begin
                wait_idle(IDLE_GAP);
                pulse_start();
            end
            drive_beat(i);
        end

        // last result due OUT_LATENCY enabled cycles after the final beat
        // two more to catch late duplicates
        wait_idle(conv_timing_pkg::OUT_LATENCY + 2);

        if (expect_idx == expect_q.size()) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_on_failure("not all expected results were produced");
        end
    end

endmodule

`default_nettype wire

// ==== hw/conv_unit.sv ====
// aclken freezes the whole unit; no output for the first KERNEL_W-1 blocks after each start
`default_nettype none

module conv_unit (
    input  wire                                             aclk,
    input  wire                                             rst_n,
    input  wire                                             aclken,
    input  wire                                             start,
    input  wire                                             s_valid,
    input  wire signed [conv_format_pkg::DATA_WIDTH-1:0]    s_pixel,
    input  wire        [conv_format_pkg::WEIGHTS_WIDTH-1:0] s_weights,
    input  wire                                             s_last,
    output logic                                            s_ready,
    output logic                                            m_valid,
    output logic signed [conv_format_pkg::ACC_WIDTH-1:0]    m_data
);

    logic [conv_format_pkg::LANE_SUMS_WIDTH-1:0] lane_sums;
    logic                                        sums_valid;
    logic                                        emit;
    logic                                        frame_start_aligned;

    // input side moves only when the output side does
    assign s_ready = aclken;

    // per lane products and block sums
    mac_lanes mac_lanes_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .aclken     (aclken),
        .s_valid    (s_valid),
        .s_last     (s_last),
        .s_pixel    (s_pixel),
        .s_weights  (s_weights),
        .lane_sums  (lane_sums),
        .sums_valid (sums_valid)
    );

    // block counting in parallel with the lanes
    column_tracker column_tracker_inst (
        .aclk                (aclk),
        .rst_n               (rst_n),
        .aclken              (aclken),
        .start               (start),
        .s_valid             (s_valid),
        .s_last              (s_last),
        .emit                (emit),
        .frame_start_aligned (frame_start_aligned)
    );

    // lane 0 to lane 2, result from the right end
    snake_chain snake_chain_inst (
        .aclk                (aclk),
        .rst_n               (rst_n),
        .aclken              (aclken),
        .lane_sums           (lane_sums),
        .sums_valid          (sums_valid),
        .emit                (emit),
        .frame_start_aligned (frame_start_aligned),
        .m_valid             (m_valid),
        .m_data              (m_data)
    );

endmodule

`default_nettype wire

// ==== hw/snake_chain.sv ====
// m_valid and m_data hold while aclken is low, so downstream counts enabled cycles only
`default_nettype none

module snake_chain (
    input  wire                                               aclk,
    input  wire                                               rst_n,
    input  wire                                               aclken,
    input  wire        [conv_format_pkg::LANE_SUMS_WIDTH-1:0] lane_sums,
    input  wire                                               sums_valid,
    input  wire                                               emit,
    input  wire                                               frame_start_aligned,
    output logic                                              m_valid,
    output logic signed [conv_format_pkg::ACC_WIDTH-1:0]      m_data
);

    // unpacked lane view
    logic signed [conv_format_pkg::ACC_WIDTH-1:0] lane_sum [conv_format_pkg::KERNEL_W];

    // carry[k] holds the partial built by lanes 0..k-1
    logic signed [conv_format_pkg::ACC_WIDTH-1:0] carry [1:conv_format_pkg::KERNEL_W-1];

    for (genvar k = 0; k < conv_format_pkg::KERNEL_W; k++) begin : g_unpack
        assign lane_sum[k] = lane_sums[k*conv_format_pkg::ACC_WIDTH +: conv_format_pkg::ACC_WIDTH];
    end

    // partials move one lane right per closed block
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int k = 1; k < conv_format_pkg::KERNEL_W; k++) begin
                carry[k] <= '0;
            end
        end else if (aclken) begin
            if (frame_start_aligned) begin
                // new frame, forget old columns
                for (int k = 1; k < conv_format_pkg::KERNEL_W; k++) begin
                    carry[k] <= '0;
                end
            end else if (sums_valid) begin
                carry[1] <= lane_sum[0];
                for (int k = 2; k < conv_format_pkg::KERNEL_W; k++) begin
                    carry[k] <= carry[k-1] + lane_sum[k-1];
                end
            end
        end
    end

    // rightmost lane finishes the column
    // starting columns are still computed, just not flagged
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
            m_data  <= '0;
        end else if (aclken) begin
            m_valid <= sums_valid & emit;
            if (sums_valid) begin
                m_data <= carry[conv_format_pkg::KERNEL_W-1] + lane_sum[conv_format_pkg::KERNEL_W-1];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/column_tracker.sv ====
// a start seen while aclken is low is held until the next enabled edge; start needs an idle pipe
`default_nettype none

module column_tracker (
    input  wire  aclk,
    input  wire  rst_n,
    input  wire  aclken,
    input  wire  start,
    input  wire  s_valid,
    input  wire  s_last,
    output logic emit,
    output logic frame_start_aligned
);

    logic                                        start_pend;
    logic                                        start_now;
    logic [conv_timing_pkg::COL_COUNT_WIDTH-1:0] col_cnt;
    logic [conv_timing_pkg::COL_COUNT_WIDTH-1:0] cnt_pipe [conv_timing_pkg::ALIGN_DELAY];
    logic [conv_timing_pkg::ALIGN_DELAY:0]       start_pipe;

    // frozen cycles must not swallow the pulse
    assign start_now = start | start_pend;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            start_pend <= 1'b0;
        end else if (aclken) begin
            start_pend <= 1'b0;
        end else if (start) begin
            start_pend <= 1'b1;
        end
    end

    // closed blocks since start, stops at all ones
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            col_cnt <= '0;
        end else if (aclken) begin
            if (start_now) begin
                col_cnt <= '0;
            end else if (s_valid && s_last && (col_cnt != '1)) begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // same depth as operand capture plus multiplier
    // one entry per enabled edge, so short blocks keep their own count
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            start_pipe <= '0;
            for (int i = 0; i < conv_timing_pkg::ALIGN_DELAY; i++) begin
                cnt_pipe[i] <= '0;
            end
        end else if (aclken) begin
            start_pipe <= {start_pipe[conv_timing_pkg::ALIGN_DELAY-1:0], start_now};
            cnt_pipe[0] <= col_cnt;
            for (int i = 1; i < conv_timing_pkg::ALIGN_DELAY; i++) begin
                cnt_pipe[i] <= cnt_pipe[i-1];
            end
        end
    end

    // count includes the block now leaving the lanes
    assign emit = cnt_pipe[conv_timing_pkg::ALIGN_DELAY-1] >= conv_timing_pkg::EMIT_COUNT;

    assign frame_start_aligned = start_pipe[conv_timing_pkg::ALIGN_DELAY];

endmodule

`default_nettype wire

// ==== hw/mac_lanes.sv ====
// all lanes share one valid/last pipe; operands are taken only while aclken and s_valid are high
`default_nettype none

module mac_lanes (
    input  wire                                               aclk,
    input  wire                                               rst_n,
    input  wire                                               aclken,
    input  wire                                               s_valid,
    input  wire                                               s_last,
    input  wire signed [conv_format_pkg::DATA_WIDTH-1:0]      s_pixel,
    input  wire        [conv_format_pkg::WEIGHTS_WIDTH-1:0]   s_weights,
    output logic       [conv_format_pkg::LANE_SUMS_WIDTH-1:0] lane_sums,
    output logic                                              sums_valid
);

    // operand capture stage
    logic                                          op_valid;
    logic                                          op_last;
    logic signed [conv_format_pkg::DATA_WIDTH-1:0] op_pixel;
    logic signed [conv_format_pkg::DATA_WIDTH-1:0] op_weight [conv_format_pkg::KERNEL_W];

    // multiplier pipe, control shared by every lane
    logic [conv_timing_pkg::MUL_DELAY-1:0]         mul_valid;
    logic [conv_timing_pkg::MUL_DELAY-1:0]         mul_last;
    logic signed [conv_format_pkg::PROD_WIDTH-1:0]
        mul_prod [conv_format_pkg::KERNEL_W][conv_timing_pkg::MUL_DELAY];

    // accumulate stage
    logic signed [conv_format_pkg::ACC_WIDTH-1:0]  prod_ext [conv_format_pkg::KERNEL_W];
    logic signed [conv_format_pkg::ACC_WIDTH-1:0]  acc      [conv_format_pkg::KERNEL_W];
    logic signed [conv_format_pkg::ACC_WIDTH-1:0]  acc_next [conv_format_pkg::KERNEL_W];
    logic signed [conv_format_pkg::ACC_WIDTH-1:0]  lane_sum [conv_format_pkg::KERNEL_W];
    logic                                          acc_restart;

    // last flag only travels with a real beat
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
            op_last  <= 1'b0;
        end else if (aclken) begin
            op_valid <= s_valid;
            op_last  <= s_valid & s_last;
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken && s_valid) begin
            op_pixel <= s_pixel;
            for (int k = 0; k < conv_format_pkg::KERNEL_W; k++) begin
                op_weight[k] <= s_weights[k*conv_format_pkg::DATA_WIDTH +: conv_format_pkg::DATA_WIDTH];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            mul_valid <= '0;
            mul_last  <= '0;
        end else if (aclken) begin
            mul_valid[0] <= op_valid;
            mul_last[0]  <= op_last;
            for (int i = 1; i < conv_timing_pkg::MUL_DELAY; i++) begin
                mul_valid[i] <= mul_valid[i-1];
                mul_last[i]  <= mul_last[i-1];
            end
        end
    end

    // signed 16x16, full 32-bit product
    always_ff @(posedge aclk) begin
        if (aclken) begin
            for (int k = 0; k < conv_format_pkg::KERNEL_W; k++) begin
                mul_prod[k][0] <= op_pixel * op_weight[k];
                for (int i = 1; i < conv_timing_pkg::MUL_DELAY; i++) begin
                    mul_prod[k][i] <= mul_prod[k][i-1];
                end
            end
        end
    end

    // sign extend to the accumulator, restart drops the old sum
    always_comb begin
        for (int k = 0; k < conv_format_pkg::KERNEL_W; k++) begin
            prod_ext[k] = mul_prod[k][conv_timing_pkg::MUL_DELAY-1];
            acc_next[k] = acc_restart ? prod_ext[k] : acc[k] + prod_ext[k];
        end
    end

    // restart is armed by a last, so the next block begins clean
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            acc_restart <= 1'b1;
            sums_valid  <= 1'b0;
            for (int k = 0; k < conv_format_pkg::KERNEL_W; k++) begin
                acc[k]      <= '0;
                lane_sum[k] <= '0;
            end
        end else if (aclken) begin
            sums_valid <= mul_valid[conv_timing_pkg::MUL_DELAY-1]
                        & mul_last[conv_timing_pkg::MUL_DELAY-1];
            if (mul_valid[conv_timing_pkg::MUL_DELAY-1]) begin
                acc_restart <= mul_last[conv_timing_pkg::MUL_DELAY-1];
                for (int k = 0; k < conv_format_pkg::KERNEL_W; k++) begin
                    acc[k] <= acc_next[k];
                    // closed block sum held until the next last
                    if (mul_last[conv_timing_pkg::MUL_DELAY-1]) begin
                        lane_sum[k] <= acc_next[k];
                    end
                end
            end
        end
    end

    // flatten, lane 0 low
    for (genvar k = 0; k < conv_format_pkg::KERNEL_W; k++) begin : g_pack
        assign lane_sums[k*conv_format_pkg::ACC_WIDTH +: conv_format_pkg::ACC_WIDTH] = lane_sum[k];
    end

endmodule

`default_nettype wire

// ==== hw/conv_timing_pkg.sv ====
// depths count enabled clock edges only; the block counter must reach KERNEL_W before it saturates
`default_nettype none

package conv_timing_pkg;

    // product register stages in every lane
    localparam int unsigned MUL_DELAY = 2;

    // edges from a taken beat to its lane sum
    // operand capture is the extra edge
    localparam int unsigned ALIGN_DELAY = MUL_DELAY + 1;

    // taken last beat to m_valid, snake stage on top
    localparam int unsigned OUT_LATENCY = ALIGN_DELAY + 1;

    // saturating count of closed blocks
    localparam int unsigned COL_COUNT_WIDTH = 2;

    // blocks closed, including the current one, before output is allowed
    localparam logic [COL_COUNT_WIDTH-1:0] EMIT_COUNT =
        COL_COUNT_WIDTH'(conv_format_pkg::KERNEL_W);

endpackage

`default_nettype wire

// ==== hw/conv_format_pkg.sv ====
// signed integer formats only; ACC_WIDTH leaves headroom for at most 256 beats per block
`default_nettype none

package conv_format_pkg;

    // signed pixel and signed weight share one width
    localparam int unsigned DATA_WIDTH = 16;

    // kernel columns, one mac lane each
    localparam int unsigned KERNEL_W = 3;

    // full width of pixel times weight
    localparam int unsigned PROD_WIDTH = 2 * DATA_WIDTH;

    // lane sums and final outputs
    // 8 bits above the product for 256 beats
    localparam int unsigned ACC_WIDTH = 40;

    // flat weight bus, lane 0 in the low bits
    localparam int unsigned WEIGHTS_WIDTH = KERNEL_W * DATA_WIDTH;

    // flat bus of all lane sums, lane 0 in the low bits
    localparam int unsigned LANE_SUMS_WIDTH = KERNEL_W * ACC_WIDTH;

endpackage

`default_nettype wire
